// File: common/lacore_pkg.sv
package lacore_pkg;

	typedef logic [31:0] word_t;     // data word or byte address
	typedef logic [4:0]  reg_addr_t; // gpr number
	typedef logic [31:0] inst_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  br_kind_t;

	localparam word_t      RESET_PC     = 32'h1c00_0000; // first fetch after reset
	localparam reg_addr_t  R0           = 5'd0;
	localparam logic [3:0] TRACE_WE_ALL = 4'hf;

	// alu operations
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_SLT = 4'd2; // signed compare
	localparam alu_op_t ALU_AND = 4'd3;
	localparam alu_op_t ALU_OR  = 4'd4;
	localparam alu_op_t ALU_XOR = 4'd5;
	localparam alu_op_t ALU_LUI = 4'd6; // src2 straight through

	localparam br_kind_t BR_NONE = 2'd0;
	localparam br_kind_t BR_BEQ  = 2'd1;
	localparam br_kind_t BR_BNE  = 2'd2;
	localparam br_kind_t BR_B    = 2'd3;

	// 3R format, opcode in inst[31:15]
	localparam logic [16:0] OPC_ADD_W = 17'h00020;
	localparam logic [16:0] OPC_SUB_W = 17'h00022;
	localparam logic [16:0] OPC_SLT   = 17'h00024;
	localparam logic [16:0] OPC_AND   = 17'h00029;
	localparam logic [16:0] OPC_OR    = 17'h0002a;
	localparam logic [16:0] OPC_XOR   = 17'h0002b;
	// 2RI12 format, inst[31:22]
	localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
	localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
	localparam logic [9:0]  OPC_ST_W    = 10'h0a6;
	localparam logic [6:0]  OPC_LU12I_W = 7'h0a;  // 1RI20, inst[31:25]
	// branches, inst[31:26]
	localparam logic [5:0]  OPC_BEQ = 6'h16;
	localparam logic [5:0]  OPC_BNE = 6'h17;
	localparam logic [5:0]  OPC_B   = 6'h14;

endpackage

// File: decode/decode_stage.sv
`timescale 1ns/100ps
module decode_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  id_load,
	input  logic                  id_valid,
	input  lacore_pkg::inst_t     inst_rdata,
	input  lacore_pkg::word_t     if_pc,
	input  logic                  fwd_ex_we,
	input  lacore_pkg::reg_addr_t fwd_ex_dest,
	input  lacore_pkg::word_t     fwd_ex_data,
	input  logic                  ex_load_pending,
	input  logic                  rf_we,
	input  lacore_pkg::reg_addr_t rf_waddr,
	input  lacore_pkg::word_t     rf_wdata,
	output lacore_pkg::word_t     id_pc,
	output lacore_pkg::alu_op_t   id_alu_op,
	output lacore_pkg::word_t     id_src1,
	output lacore_pkg::word_t     id_src2,
	output lacore_pkg::word_t     id_store_data,
	output lacore_pkg::reg_addr_t id_dest,
	output logic                  id_gpr_we,
	output logic                  id_is_load,
	output logic                  id_is_store,
	output lacore_pkg::br_kind_t  id_br_kind,
	output lacore_pkg::word_t     id_br_offset,
	output logic                  id_stall
);
	import lacore_pkg::*;

	inst_t id_inst;
	reg_addr_t rj, rkd;
	logic is_add, is_sub, is_slt, is_and, is_or, is_xor;
	logic is_addi, is_lu12i, is_beq, is_bne, is_b;
	logic use_imm, use_rj, use_rkd, rd_on_port2;
	logic ex_hit1, ex_hit2, wb_hit1, wb_hit2;
	word_t rf_rdata1, rf_rdata2, rj_val, rkd_val, imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			id_inst <= '0; // decodes as nothing
		end else if (id_load) begin
			id_inst <= inst_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (id_load) begin
			id_pc <= if_pc;
		end
	end

	assign is_add   = id_inst[31:15] == OPC_ADD_W;
	assign is_sub   = id_inst[31:15] == OPC_SUB_W;
	assign is_slt   = id_inst[31:15] == OPC_SLT;
	assign is_and   = id_inst[31:15] == OPC_AND;
	assign is_or    = id_inst[31:15] == OPC_OR;
	assign is_xor   = id_inst[31:15] == OPC_XOR;
	assign is_addi  = id_inst[31:22] == OPC_ADDI_W;
	assign id_is_load  = id_inst[31:22] == OPC_LD_W;
	assign id_is_store = id_inst[31:22] == OPC_ST_W;
	assign is_lu12i = id_inst[31:25] == OPC_LU12I_W;
	assign is_beq   = id_inst[31:26] == OPC_BEQ;
	assign is_bne   = id_inst[31:26] == OPC_BNE;
	assign is_b     = id_inst[31:26] == OPC_B;

	assign use_imm     = is_addi || is_lu12i || id_is_load || id_is_store;
	assign rd_on_port2 = id_is_store || is_beq || is_bne; // rd read as store or compare value
	assign use_rj      = !(is_lu12i || is_b);
	assign use_rkd     = is_add || is_sub || is_slt || is_and || is_or || is_xor || rd_on_port2;

	assign rj      = id_inst[9:5];
	assign rkd     = rd_on_port2 ? id_inst[4:0] : id_inst[14:10];
	assign id_dest = id_inst[4:0];

	assign id_gpr_we = is_add || is_sub || is_slt || is_and || is_or || is_xor
		|| is_addi || is_lu12i || id_is_load;

	assign id_alu_op = is_sub   ? ALU_SUB :
	                   is_slt   ? ALU_SLT :
	                   is_and   ? ALU_AND :
	                   is_or    ? ALU_OR  :
	                   is_xor   ? ALU_XOR :
	                   is_lu12i ? ALU_LUI :
	                              ALU_ADD; // add, addi, address calc

	assign id_br_kind = is_beq ? BR_BEQ :
	                    is_bne ? BR_BNE :
	                    is_b   ? BR_B   : BR_NONE;

	// si20 << 12 for lu12i, else sign-extended si12
	assign imm = is_lu12i ? {id_inst[24:5], 12'h000} : {{20{id_inst[21]}}, id_inst[21:10]};
	// b keeps offs[25:16] in inst[9:0]
	assign id_br_offset = is_b ? {{4{id_inst[9]}}, id_inst[9:0], id_inst[25:10], 2'b00}
	                           : {{14{id_inst[25]}}, id_inst[25:10], 2'b00};

	reg_file u_rf (
		.clk(clk), .raddr1(rj), .raddr2(rkd),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2)
	);

	// EX first, then WB, then the file
	assign ex_hit1 = fwd_ex_we && (fwd_ex_dest == rj) && (rj != R0);
	assign ex_hit2 = fwd_ex_we && (fwd_ex_dest == rkd) && (rkd != R0);
	assign wb_hit1 = rf_we && (rf_waddr == rj);   // rf_we already excludes r0
	assign wb_hit2 = rf_we && (rf_waddr == rkd);
	assign rj_val  = ex_hit1 ? fwd_ex_data : wb_hit1 ? rf_wdata : rf_rdata1;
	assign rkd_val = ex_hit2 ? fwd_ex_data : wb_hit2 ? rf_wdata : rf_rdata2;

	assign id_src1       = rj_val;
	assign id_src2       = use_imm ? imm : rkd_val;
	assign id_store_data = rkd_val;

	// load result not ready until WB
	assign id_stall = id_valid && ex_load_pending && (fwd_ex_dest != R0)
		&& ((use_rj && rj == fwd_ex_dest) || (use_rkd && rkd == fwd_ex_dest));

endmodule

// File: decode/reg_file.sv
`timescale 1ns/100ps
module reg_file (
	input  logic                  clk,
	input  lacore_pkg::reg_addr_t raddr1,
	input  lacore_pkg::reg_addr_t raddr2,
	input  logic                  we,
	input  lacore_pkg::reg_addr_t waddr,
	input  lacore_pkg::word_t     wdata,
	output lacore_pkg::word_t     rdata1,
	output lacore_pkg::word_t     rdata2
);
	import lacore_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (we && waddr != R0) begin // r0 hardwired
			regs[waddr] <= wdata;
		end
	end

	// same-cycle write is covered by WB forwarding
	assign rdata1 = (raddr1 == R0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == R0) ? '0 : regs[raddr2];

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/100ps
module execute_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ex_load,
	input  logic                  ex_valid,
	input  lacore_pkg::word_t     id_pc,
	input  lacore_pkg::alu_op_t   id_alu_op,
	input  lacore_pkg::word_t     id_src1,
	input  lacore_pkg::word_t     id_src2,
	input  lacore_pkg::word_t     id_store_data,
	input  lacore_pkg::reg_addr_t id_dest,
	input  logic                  id_gpr_we,
	input  logic                  id_is_load,
	input  logic                  id_is_store,
	input  lacore_pkg::br_kind_t  id_br_kind,
	input  lacore_pkg::word_t     id_br_offset,
	output logic                  fwd_ex_we,
	output lacore_pkg::reg_addr_t fwd_ex_dest,
	output lacore_pkg::word_t     fwd_ex_data,
	output logic                  ex_load_pending,
	output logic                  br_taken,
	output lacore_pkg::word_t     br_target,
	output logic                  data_req,
	output logic                  data_we,
	output lacore_pkg::word_t     data_addr,
	output lacore_pkg::word_t     data_wdata,
	output lacore_pkg::word_t     ex_pc,
	output lacore_pkg::word_t     ex_result,
	output lacore_pkg::reg_addr_t ex_dest,
	output logic                  ex_gpr_we,
	output logic                  ex_is_load
);
	import lacore_pkg::*;

	alu_op_t ex_alu_op;
	word_t ex_src1, ex_src2, ex_store_data, ex_br_offset;
	logic ex_is_store;
	br_kind_t ex_br_kind;
	logic br_cond;

	// control bits
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_gpr_we   <= 1'b0;
			ex_is_load  <= 1'b0;
			ex_is_store <= 1'b0;
			ex_br_kind  <= BR_NONE;
		end else if (ex_load) begin
			ex_gpr_we   <= id_gpr_we;
			ex_is_load  <= id_is_load;
			ex_is_store <= id_is_store;
			ex_br_kind  <= id_br_kind;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_load) begin
			ex_pc         <= id_pc;
			ex_alu_op     <= id_alu_op;
			ex_src1       <= id_src1;
			ex_src2       <= id_src2;
			ex_store_data <= id_store_data;
			ex_dest       <= id_dest;
			ex_br_offset  <= id_br_offset;
		end
	end

	always_comb begin
		case (ex_alu_op)
			ALU_SUB: ex_result = ex_src1 - ex_src2;
			ALU_SLT: ex_result = {31'b0, $signed(ex_src1) < $signed(ex_src2)};
			ALU_AND: ex_result = ex_src1 & ex_src2;
			ALU_OR:  ex_result = ex_src1 | ex_src2;
			ALU_XOR: ex_result = ex_src1 ^ ex_src2;
			ALU_LUI: ex_result = ex_src2;
			default: ex_result = ex_src1 + ex_src2; // add, mem address
		endcase
	end

	always_comb begin
		case (ex_br_kind)
			BR_BEQ:  br_cond = ex_src1 == ex_store_data;
			BR_BNE:  br_cond = ex_src1 != ex_store_data;
			BR_B:    br_cond = 1'b1;
			default: br_cond = 1'b0;
		endcase
	end

	assign br_taken  = ex_valid && br_cond;
	assign br_target = ex_pc + ex_br_offset; // pc-relative

	// data port, read data comes back next cycle in WB
	assign data_req   = ex_valid && (ex_is_load || ex_is_store);
	assign data_we    = ex_valid && ex_is_store;
	assign data_addr  = ex_result;
	assign data_wdata = ex_store_data;

	assign fwd_ex_we       = ex_valid && ex_gpr_we && !ex_is_load; // load value not here yet
	assign fwd_ex_dest     = ex_dest;
	assign fwd_ex_data     = ex_result;
	assign ex_load_pending = ex_valid && ex_is_load;

endmodule

// File: result/writeback_stage.sv
`timescale 1ns/100ps
module writeback_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wb_valid,
	input  lacore_pkg::word_t     ex_pc,
	input  lacore_pkg::word_t     ex_result,
	input  lacore_pkg::reg_addr_t ex_dest,
	input  logic                  ex_gpr_we,
	input  logic                  ex_is_load,
	input  lacore_pkg::word_t     data_rdata, // answer to last cycle's read
	output logic                  rf_we,
	output lacore_pkg::reg_addr_t rf_waddr,
	output lacore_pkg::word_t     rf_wdata,
	output lacore_pkg::word_t     debug_wb_pc,
	output logic [3:0]            debug_wb_rf_we,
	output lacore_pkg::reg_addr_t debug_wb_rf_wnum,
	output lacore_pkg::word_t     debug_wb_rf_wdata
);
	import lacore_pkg::*;

	word_t wb_pc, wb_result;
	reg_addr_t wb_dest;
	logic wb_gpr_we, wb_is_load;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_gpr_we  <= 1'b0;
			wb_is_load <= 1'b0;
		end else begin
			wb_gpr_we  <= ex_gpr_we;
			wb_is_load <= ex_is_load;
		end
	end

	always_ff @(posedge clk) begin
		wb_pc     <= ex_pc;
		wb_result <= ex_result;
		wb_dest   <= ex_dest;
	end

	assign rf_we    = wb_valid && wb_gpr_we && (wb_dest != R0); // r0 writes dropped
	assign rf_waddr = wb_dest;
	assign rf_wdata = wb_is_load ? data_rdata : wb_result;

	// trace mirrors the gpr write
	assign debug_wb_pc       = wb_pc;
	assign debug_wb_rf_we    = rf_we ? TRACE_WE_ALL : 4'h0;
	assign debug_wb_rf_wnum  = wb_dest;
	assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: rtl/core_top.sv
`timescale 1ns/100ps
module core_top (
	input  logic                  clk,
	input  logic                  reset,
	input  lacore_pkg::inst_t     inst_rdata,
	input  lacore_pkg::word_t     data_rdata,
	output lacore_pkg::word_t     inst_addr,
	output logic                  data_req,
	output logic                  data_we,
	output lacore_pkg::word_t     data_addr,
	output lacore_pkg::word_t     data_wdata,
	output lacore_pkg::word_t     debug_wb_pc,
	output logic [3:0]            debug_wb_rf_we,
	output lacore_pkg::reg_addr_t debug_wb_rf_wnum,
	output lacore_pkg::word_t     debug_wb_rf_wdata
);
	import lacore_pkg::*;

	// pipeline control
	logic id_valid, ex_valid, wb_valid;
	logic if_advance, id_load, ex_load, id_stall;
	logic br_taken;
	word_t br_target;
	word_t if_pc;

	// ID to EX payload
	word_t id_pc, id_src1, id_src2, id_store_data, id_br_offset;
	alu_op_t id_alu_op;
	reg_addr_t id_dest;
	logic id_gpr_we, id_is_load, id_is_store;
	br_kind_t id_br_kind;

	// EX back to ID and on to WB
	logic fwd_ex_we, ex_load_pending;
	reg_addr_t fwd_ex_dest, ex_dest;
	word_t fwd_ex_data, ex_pc, ex_result;
	logic ex_gpr_we, ex_is_load;

	// WB register write, also forwarded
	logic rf_we;
	reg_addr_t rf_waddr;
	word_t rf_wdata;

	assign inst_addr = if_pc; // rom answers in the same cycle

	fetch_stage u_fetch (
		.clk(clk), .reset(reset), .if_advance(if_advance),
		.br_taken(br_taken), .br_target(br_target), .if_pc(if_pc)
	);

	pipe_valid_ctrl u_ctrl (
		.clk(clk), .reset(reset), .id_stall(id_stall), .br_taken(br_taken),
		.id_valid(id_valid), .ex_valid(ex_valid), .wb_valid(wb_valid),
		.if_advance(if_advance), .id_load(id_load), .ex_load(ex_load)
	);

	decode_stage u_decode (
		.clk(clk), .reset(reset), .id_load(id_load), .id_valid(id_valid),
		.inst_rdata(inst_rdata), .if_pc(if_pc),
		.fwd_ex_we(fwd_ex_we), .fwd_ex_dest(fwd_ex_dest), .fwd_ex_data(fwd_ex_data),
		.ex_load_pending(ex_load_pending),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.id_pc(id_pc), .id_alu_op(id_alu_op), .id_src1(id_src1), .id_src2(id_src2),
		.id_store_data(id_store_data), .id_dest(id_dest), .id_gpr_we(id_gpr_we),
		.id_is_load(id_is_load), .id_is_store(id_is_store), .id_br_kind(id_br_kind),
		.id_br_offset(id_br_offset), .id_stall(id_stall)
	);

	execute_stage u_execute (
		.clk(clk), .reset(reset), .ex_load(ex_load), .ex_valid(ex_valid),
		.id_pc(id_pc), .id_alu_op(id_alu_op), .id_src1(id_src1), .id_src2(id_src2),
		.id_store_data(id_store_data), .id_dest(id_dest), .id_gpr_we(id_gpr_we),
		.id_is_load(id_is_load), .id_is_store(id_is_store), .id_br_kind(id_br_kind),
		.id_br_offset(id_br_offset),
		.fwd_ex_we(fwd_ex_we), .fwd_ex_dest(fwd_ex_dest), .fwd_ex_data(fwd_ex_data),
		.ex_load_pending(ex_load_pending), .br_taken(br_taken), .br_target(br_target),
		.data_req(data_req), .data_we(data_we), .data_addr(data_addr),
		.data_wdata(data_wdata), .ex_pc(ex_pc), .ex_result(ex_result),
		.ex_dest(ex_dest), .ex_gpr_we(ex_gpr_we), .ex_is_load(ex_is_load)
	);

	writeback_stage u_writeback (
		.clk(clk), .reset(reset), .wb_valid(wb_valid),
		.ex_pc(ex_pc), .ex_result(ex_result), .ex_dest(ex_dest),
		.ex_gpr_we(ex_gpr_we), .ex_is_load(ex_is_load), .data_rdata(data_rdata),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
		.debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/100ps
module fetch_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              if_advance, // IF hands its instruction to ID
	input  logic              br_taken,   // resolved in EX
	input  lacore_pkg::word_t br_target,
	output lacore_pkg::word_t if_pc
);
	import lacore_pkg::*;

	word_t pc_seq;

	assign pc_seq = if_pc + 32'd4; // next sequential fetch

	// redirect wins over sequential advance
	// wrong-path word in IF just gets replaced
	always_ff @(posedge clk) begin
		if (reset) begin
			if_pc <= RESET_PC;
		end else if (br_taken) begin
			if_pc <= br_target;
		end else if (if_advance) begin
			if_pc <= pc_seq;
		end
	end

endmodule

// File: rtl/pipe_valid_ctrl.sv
`timescale 1ns/100ps
module pipe_valid_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic id_stall, // load-use in ID
	input  logic br_taken, // flush IF and ID
	output logic id_valid,
	output logic ex_valid,
	output logic wb_valid,
	output logic if_advance,
	output logic id_load,
	output logic ex_load
);

	logic if_valid;
	logic id_ready_go;
	logic id_allowin;

	// EX and WB never wait
	assign id_ready_go = id_valid && !id_stall;
	assign id_allowin  = !id_valid || id_ready_go;

	assign id_load    = if_valid && id_allowin; // IF -> ID
	assign if_advance = id_load;
	assign ex_load    = id_ready_go && !br_taken; // ID -> EX, killed by branch

	always_ff @(posedge clk) begin
		if (reset) begin
			if_valid <= 1'b0;
			id_valid <= 1'b0;
			ex_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			if_valid <= 1'b1; // rom never stalls
			if (br_taken) begin
				id_valid <= 1'b0;
			end else if (id_allowin) begin
				id_valid <= if_valid;
			end
			ex_valid <= ex_load; // bubble on stall or flush
			wb_valid <= ex_valid;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core -f sources.f --Mdir obj_dir -o tb_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
exit 0

// File: sources.f
common/lacore_pkg.sv
rtl/fetch_stage.sv
rtl/pipe_valid_ctrl.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
result/writeback_stage.sv
rtl/core_top.sv
verification/tb_core.sv

// File: verification/tb_core.sv
`timescale 1ns/100ps
module tb_core;
	import lacore_pkg::*;

	localparam int NUM_TESTS   = 5;
	localparam int TEST_CYCLES = 200; // budget per test
	localparam int ROM_WORDS   = 64;
	localparam word_t ROM_BYTES = 32'd256;

	logic clk = 1'b0;
	logic reset;
	inst_t inst_rdata;
	word_t data_rdata;
	word_t inst_addr, data_addr, data_wdata;
	logic data_req, data_we;
	word_t debug_wb_pc, debug_wb_rf_wdata;
	logic [3:0] debug_wb_rf_we;
	reg_addr_t debug_wb_rf_wnum;

	inst_t rom [ROM_WORDS];
	logic [5:0] prog_len; // next free rom slot
	word_t dmem [word_t]; // sparse, only stored words
	word_t rd_addr;       // read address seen in EX
	word_t rng;

	// expected trace, built with the program
	word_t exp_pc [$];
	reg_addr_t exp_num [$];
	word_t exp_data [$];
	// observed trace and stores
	word_t got_pc [$];
	reg_addr_t got_num [$];
	word_t got_data [$];
	word_t st_addr [$];
	word_t st_data [$];

	core_top uut (
		.clk(clk), .reset(reset), .inst_rdata(inst_rdata), .data_rdata(data_rdata),
		.inst_addr(inst_addr), .data_req(data_req), .data_we(data_we),
		.data_addr(data_addr), .data_wdata(data_wdata), .debug_wb_pc(debug_wb_pc),
		.debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
		.debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	always #2 clk = ~clk; // 4 ns period

	function automatic word_t fill_word(input word_t addr);
		return addr ^ 32'h5a5a_a5a5; // never-stored words
	endfunction

	function automatic word_t read_word(input word_t addr);
		if (dmem.exists(addr)) begin
			return dmem[addr];
		end
		return fill_word(addr);
	endfunction

	function automatic inst_t rom_word(input word_t addr);
		word_t offs;
		offs = addr - RESET_PC;
		if (offs < ROM_BYTES) begin
			return rom[offs[7:2]];
		end
		return '0; // decodes as nothing
	endfunction

	function automatic word_t xorshift32(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic word_t upper20(input logic [19:0] v);
		return {v, 12'h000};
	endfunction

	// instruction encoders
	function automatic inst_t enc_3r(input logic [16:0] opc, input reg_addr_t rd, rj, rk);
		return {opc, rk, rj, rd};
	endfunction

	function automatic inst_t enc_2ri12(input logic [9:0] opc, input reg_addr_t rd, rj,
		input logic [11:0] si12);
		return {opc, si12, rj, rd};
	endfunction

	function automatic inst_t enc_lu12i(input reg_addr_t rd, input logic [19:0] si20);
		return {OPC_LU12I_W, si20, rd};
	endfunction

	function automatic inst_t enc_br(input logic [5:0] opc, input reg_addr_t rj, rd,
		input logic [15:0] offs);
		return {opc, offs, rj, rd}; // offset counted in words
	endfunction

	function automatic inst_t enc_b(input logic [25:0] offs);
		return {OPC_B, offs[15:0], offs[25:16]}; // high part lands in [9:0]
	endfunction

	// memories answer mid-cycle
	always @(negedge clk) begin
		inst_rdata <= rom_word(inst_addr);
		data_rdata <= read_word(rd_addr); // for the load now in WB
		if (data_req && !data_we) begin
			rd_addr <= data_addr;
		end
	end

	// stores and trace sampled at the edge that ends the cycle
	always @(posedge clk) begin
		if (data_req && data_we) begin
			dmem[data_addr] = data_wdata;
			st_addr.push_back(data_addr);
			st_data.push_back(data_wdata);
		end
		if (debug_wb_rf_we != 4'h0) begin
			check_we("debug_wb_rf_we", debug_wb_rf_we, 4'hf); // all byte lanes
			got_pc.push_back(debug_wb_pc);
			got_num.push_back(debug_wb_rf_wnum);
			got_data.push_back(debug_wb_rf_wdata);
		end
	end

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("** Error: %s = %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("** Error: %s = %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_pc(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("** Error: %s = %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_we(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			fail_stop($sformatf("** Error: %s = %h, expected %h", name, got, exp));
		end
	endtask

	task automatic put(input inst_t w);
		rom[prog_len] = w;
		prog_len = prog_len + 6'd1;
	endtask

	// expected write of the instruction just placed
	task automatic expect_wr(input reg_addr_t r, input word_t v);
		exp_pc.push_back(RESET_PC + {24'd0, prog_len - 6'd1, 2'b00});
		exp_num.push_back(r);
		exp_data.push_back(v);
	endtask

	// random constant through lu12i.w then addi.w
	task automatic put_const(input reg_addr_t r, output word_t v);
		logic [19:0] hi;
		logic [11:0] lo;
		rng = xorshift32(rng);
		hi = rng[31:12];
		lo = rng[11:0];
		put(enc_lu12i(r, hi));
		expect_wr(r, upper20(hi));
		put(enc_2ri12(OPC_ADDI_W, r, r, lo)); // takes r from EX
		v = upper20(hi) + sext12(lo);
		expect_wr(r, v);
	endtask

	task automatic begin_test;
		@(negedge clk);
		reset = 1'b1; // rom rewritten under reset
		rom = '{default: '0};
		prog_len = '0;
		exp_pc.delete();
		exp_num.delete();
		exp_data.delete();
	endtask

	task automatic run_program(input bit watch_idle);
		repeat (2) begin
			@(negedge clk);
			if (watch_idle && (data_req || debug_wb_rf_we != 4'h0)) begin
				fail_stop("data request or trace write seen during reset");
			end
		end
		reset = 1'b0;
		got_pc.delete();
		got_num.delete();
		got_data.delete();
		st_addr.delete();
		st_data.delete();
		while (watch_idle && debug_wb_rf_we == 4'h0) begin
			if (data_req) begin
				fail_stop("data_req went high before the first write retired");
			end
			@(negedge clk);
		end
		while (got_pc.size() < exp_pc.size()) begin
			@(negedge clk); // watchdog covers a stuck core
		end
		repeat (10) @(negedge clk); // quiet tail, loop writes nothing
		if (got_pc.size() != exp_pc.size()) begin
			fail_stop($sformatf("saw %0d trace writes where %0d were expected",
				got_pc.size(), exp_pc.size()));
		end
		for (int i = 0; i < exp_pc.size(); i++) begin
			check_pc($sformatf("debug_wb_pc[%0d]", i), got_pc[i], exp_pc[i]);
			check_reg($sformatf("debug_wb_rf_wnum[%0d]", i), got_num[i], exp_num[i]);
			check_word($sformatf("debug_wb_rf_wdata[%0d]", i), got_data[i], exp_data[i]);
		end
	endtask

	task automatic test_alu_forwarding;
		word_t a, b, s, d, lt, an, o;
		begin_test();
		put_const(5'd1, a);
		put_const(5'd2, b);
		s = a + b;
		put(enc_3r(OPC_ADD_W, 5'd3, 5'd1, 5'd2)); // r2 from EX
		expect_wr(5'd3, s);
		d = s - b;
		put(enc_3r(OPC_SUB_W, 5'd4, 5'd3, 5'd2)); // r3 from EX, r2 from WB
		expect_wr(5'd4, d);
		lt = {31'b0, $signed(s) < $signed(a)};
		put(enc_3r(OPC_SLT, 5'd5, 5'd3, 5'd1)); // r3 at distance 2
		expect_wr(5'd5, lt);
		an = s & d;
		put(enc_3r(OPC_AND, 5'd6, 5'd3, 5'd4));
		expect_wr(5'd6, an);
		o = an | b;
		put(enc_3r(OPC_OR, 5'd7, 5'd6, 5'd2));
		expect_wr(5'd7, o);
		put(enc_3r(OPC_XOR, 5'd8, 5'd7, 5'd6)); // both bypass paths at once
		expect_wr(5'd8, o ^ an);
		put(enc_b(26'd0));
		run_program(1'b0);
	endtask

	task automatic test_immediates;
		begin_test();
		put(enc_2ri12(OPC_ADDI_W, 5'd9, 5'd0, 12'hffb));
		expect_wr(5'd9, sext12(12'hffb));
		put(enc_2ri12(OPC_ADDI_W, 5'd10, 5'd9, 12'h800)); // most negative si12
		expect_wr(5'd10, sext12(12'hffb) + sext12(12'h800));
		put(enc_lu12i(5'd11, 20'h80001));
		expect_wr(5'd11, upper20(20'h80001));
		put(enc_2ri12(OPC_ADDI_W, 5'd11, 5'd11, 12'h9ab));
		expect_wr(5'd11, upper20(20'h80001) + sext12(12'h9ab));
		put(enc_lu12i(5'd12, 20'hfffff));
		expect_wr(5'd12, upper20(20'hfffff));
		put(enc_b(26'd0));
		run_program(1'b0);
	endtask

	task automatic test_load_use;
		word_t base, v, far_addr;
		begin_test();
		base = upper20(20'h1c010);
		put(enc_lu12i(5'd13, 20'h1c010));
		expect_wr(5'd13, base);
		put_const(5'd14, v);
		put(enc_2ri12(OPC_ST_W, 5'd14, 5'd13, 12'h010)); // store data bypassed from EX
		put(enc_2ri12(OPC_LD_W, 5'd15, 5'd13, 12'h010));
		expect_wr(5'd15, v);
		put(enc_3r(OPC_ADD_W, 5'd16, 5'd15, 5'd14)); // one bubble here
		expect_wr(5'd16, v + v);
		far_addr = base + sext12(12'hff0);
		put(enc_2ri12(OPC_LD_W, 5'd17, 5'd13, 12'hff0)); // untouched word
		expect_wr(5'd17, fill_word(far_addr));
		put(enc_3r(OPC_SUB_W, 5'd18, 5'd17, 5'd15));
		expect_wr(5'd18, fill_word(far_addr) - v);
		put(enc_b(26'd0));
		run_program(1'b0);
		if (st_addr.size() != 1) begin
			fail_stop("expected exactly one store on the data port");
		end
		check_word("data_addr", st_addr[0], base + 32'h10);
		check_word("data_wdata", st_data[0], v);
	endtask

	task automatic test_branches;
		inst_t marker;
		marker = enc_2ri12(OPC_ADDI_W, 5'd30, 5'd0, 12'h7ee); // must never retire
		begin_test();
		put(enc_2ri12(OPC_ADDI_W, 5'd20, 5'd0, 12'd1));
		expect_wr(5'd20, 32'd1);
		put(enc_2ri12(OPC_ADDI_W, 5'd21, 5'd0, 12'd1));
		expect_wr(5'd21, 32'd1);
		put(enc_2ri12(OPC_ADDI_W, 5'd22, 5'd0, 12'd2));
		expect_wr(5'd22, 32'd2);
		put(enc_br(OPC_BEQ, 5'd20, 5'd21, 16'd3)); // equal, taken
		put(marker);
		put(marker);
		put(enc_br(OPC_BEQ, 5'd20, 5'd22, 16'd2)); // unequal, falls through
		put(enc_2ri12(OPC_ADDI_W, 5'd23, 5'd0, 12'd3));
		expect_wr(5'd23, 32'd3);
		put(enc_br(OPC_BNE, 5'd20, 5'd22, 16'd3)); // taken
		put(marker);
		put(marker);
		put(enc_b(26'd3));
		put(marker);
		put(marker);
		put(enc_2ri12(OPC_ADDI_W, 5'd24, 5'd0, 12'd4));
		expect_wr(5'd24, 32'd4);
		put(enc_b(26'd0));
		run_program(1'b0);
	endtask

	task automatic test_r0;
		begin_test();
		put(enc_2ri12(OPC_ADDI_W, 5'd0, 5'd0, 12'h123)); // dropped, no trace
		put(enc_2ri12(OPC_ADDI_W, 5'd25, 5'd0, 12'h055)); // r0 not bypassed from EX
		expect_wr(5'd25, 32'h55);
		put(enc_3r(OPC_ADD_W, 5'd26, 5'd0, 5'd0));
		expect_wr(5'd26, 32'd0);
		put(enc_3r(OPC_ADD_W, 5'd0, 5'd25, 5'd25));
		put(enc_3r(OPC_OR, 5'd27, 5'd0, 5'd25));
		expect_wr(5'd27, 32'h55);
		put(enc_b(26'd0));
		run_program(1'b1); // also watch the idle outputs
	endtask

	initial begin
		reset = 1'b1;
		inst_rdata = '0;
		data_rdata = '0;
		rd_addr = '0;
		rng = 32'hc7f13e13;
		prog_len = '0;
		test_alu_forwarding();
		test_immediates();
		test_load_use();
		test_branches();
		test_r0();
		$display("=== PASS ===");
		$finish;
	end

	// watchdog
	initial begin
		#(NUM_TESTS * TEST_CYCLES * 4);
		fail_stop("timeout, the tests did not complete within the cycle budget");
	end

endmodule
